//--- compile.f
+incdir+dv
src/pe_pkg.sv
src/periph_bus_if.sv
src/pe_bus_decoder.sv
src/pe_rtc.sv
src/br_local_port.sv
src/pe_top.sv
dv/tb_pe_top.sv

//--- dv/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// One step of the 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

//////////////////////////////
// Reference model
//////////////////////////////

// Expected {dmem, plic, ni} enables for a request to addr
function automatic logic [2:0] expected_enables(input logic [31:0] addr);
    logic [2:0] e;
    case (addr[31:24])
        region_dmem: e = 3'b100;
        region_plic: e = 3'b010;
        region_ni:   e = 3'b001;
        default:     e = 3'b000;
    endcase
    return e;
endfunction

function automatic logic [31:0] rtc_addr(input logic [3:0] off);
    return {region_rtc, 20'h0, off};
endfunction

//////////////////////////////
// Checks
//////////////////////////////

task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks_run++;
    assert (act === exp) else begin
        $display("** Error %s: %s expected %0h, actual %0h", test_name, what, exp, act);
        test_errs++;
    end
endtask

task automatic check_true(input string what, input logic cond);
    checks_run++;
    assert (cond === 1'b1) else begin
        $display("Failure in test %s: %s", test_name, what);
        test_errs++;
    end
endtask

`endif

//--- dv/tb_pe_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pe_top
    import pe_pkg::*;
();

    localparam int unsigned tile_x     = 2;
    localparam int unsigned tile_y     = 1;
    localparam int unsigned clk_per_ns = 100;
    localparam int unsigned settle_ns  = 25;

    // Tile (2, 1) in a mesh four tiles wide
    localparam int unsigned exp_seq_addr = 6;

    // Rough cycle count of each test
    localparam int unsigned len_reset  = 4;
    localparam int unsigned len_decode = 35;
    localparam int unsigned len_read   = 30;
    localparam int unsigned len_timer  = 30;
    localparam int unsigned len_split  = 20;
    localparam int unsigned len_inject = 50;
    localparam int unsigned len_total  = len_reset + len_decode + len_read
                                       + len_timer + len_split + len_inject;
    localparam int unsigned watchdog_ns = (len_total + 50) * clk_per_ns;

    logic clk_i;
    logic rst_ni;
    logic cpu_en_i;
    logic [3:0] cpu_we_i;
    logic [31:0] cpu_addr_i, cpu_wdata_i, cpu_rdata_o;
    logic dmem_en_o, plic_en_o, ni_en_o, mti_o;
    logic [mem_addr_w-1:0] dmem_addr_o;
    logic [31:0] dmem_rdata_i, plic_rdata_i, ni_rdata_i;
    logic br_rx_req_i, br_rx_ack_o, br_mon_req_o, br_mon_ack_i, br_svc_req_o, br_svc_ack_i;
    logic br_ni_req_i, br_ni_ack_o, br_tx_req_o, br_tx_ack_i;
    logic [br_payload_w-1:0] br_rx_payload_i, br_mon_payload_o, br_svc_payload_o;
    logic [br_payload_w-1:0] br_ni_payload_i, br_tx_payload_o;
    logic [br_addr_w-1:0] br_rx_seq_source_i, br_rx_producer_i;
    logic [br_addr_w-1:0] br_mon_seq_source_o, br_mon_producer_o;
    logic [br_addr_w-1:0] br_svc_seq_source_o, br_svc_producer_o;
    logic [br_addr_w-1:0] br_ni_seq_target_i, br_ni_producer_i;
    logic [br_addr_w-1:0] br_tx_seq_target_o, br_tx_seq_source_o, br_tx_producer_o;
    logic [7:0] br_rx_ksvc_i, br_svc_ksvc_o, br_ni_ksvc_i, br_tx_ksvc_o;
    logic [br_svc_w-1:0] br_rx_service_i, br_ni_service_i, br_tx_service_o;
    logic [br_msvc_w-1:0] br_mon_msvc_o;
    logic [br_id_w-1:0] br_tx_id_o;

    logic [31:0] rng_state;
    string       test_name;
    int          test_errs;
    int          checks_run;
    int          tests_run;
    int          tests_failed;
    int          errors_total;

    `include "tb_checks.svh"

    pe_top #(
        .pe_x (tile_x),
        .pe_y (tile_y)
    ) dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #(clk_per_ns / 2) clk_i = ~clk_i;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: tests did not finish within %0d ns", watchdog_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    //////////////////////////////
    // Sequencing and bus access
    //////////////////////////////

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        errors_total += test_errs;
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errs);
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk_i);
        cpu_en_i    = 1'b1;
        cpu_we_i    = 4'hF;
        cpu_addr_i  = addr;
        cpu_wdata_i = data;
        @(negedge clk_i);
        cpu_en_i = 1'b0;
        cpu_we_i = 4'h0;
    endtask

    // Data is sampled in the cycle after the request
    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk_i);
        cpu_en_i   = 1'b1;
        cpu_we_i   = 4'h0;
        cpu_addr_i = addr;
        @(negedge clk_i);
        cpu_en_i = 1'b0;
        #(settle_ns);
        data = cpu_rdata_o;
    endtask

    task automatic drive_rdata();
        dmem_rdata_i = next_rand();
        plic_rdata_i = next_rand();
        ni_rdata_i   = next_rand();
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_reset();
        begin_test("reset state");
        #(settle_ns);
        check_val("dmem_en_o", 64'(0), 64'(dmem_en_o));
        check_val("plic_en_o", 64'(0), 64'(plic_en_o));
        check_val("ni_en_o", 64'(0), 64'(ni_en_o));
        check_val("br_mon_req_o", 64'(0), 64'(br_mon_req_o));
        check_val("br_svc_req_o", 64'(0), 64'(br_svc_req_o));
        check_val("br_tx_req_o", 64'(0), 64'(br_tx_req_o));
        check_val("mti_o", 64'(0), 64'(mti_o));
        check_val("br_tx_id_o", 64'(0), 64'(br_tx_id_o));
        end_test();
    endtask

    task automatic test_decode();
        logic [7:0]  regions [5];
        logic [31:0] r;
        logic [31:0] addr;
        begin_test("region decode");
        regions = '{region_dmem, region_rtc, region_plic, region_ni, 8'h00};
        for (int k = 0; k < 5; k++) begin
            for (int n = 0; n < 6; n++) begin
                r    = next_rand();
                addr = {regions[k], r[23:0]};
                // Last group picks a region outside the map
                if (k == 4) begin
                    addr[31:24] = r[31:24];
                    if (r[31:24] inside {region_dmem, region_rtc, region_plic, region_ni}) begin
                        addr[31:24] = 8'h80;
                    end
                end
                @(negedge clk_i);
                cpu_en_i   = 1'b1;
                cpu_we_i   = 4'h0;
                cpu_addr_i = addr;
                #(settle_ns);
                check_val("enables", 64'(expected_enables(addr)),
                          64'({dmem_en_o, plic_en_o, ni_en_o}));
                check_val("dmem_addr_o", 64'(addr[23:0]), 64'(dmem_addr_o));
            end
        end
        @(negedge clk_i);
        cpu_en_i   = 1'b0;
        cpu_addr_i = {region_dmem, 24'h0};
        #(settle_ns);
        check_val("idle enables", 64'(0), 64'({dmem_en_o, plic_en_o, ni_en_o}));
        end_test();
    endtask

    task automatic test_read_return();
        logic [7:0]  regions [3];
        logic [31:0] r;
        logic [31:0] exp;
        begin_test("read return");
        regions = '{region_dmem, region_plic, region_ni};
        for (int k = 0; k < 3; k++) begin
            for (int n = 0; n < 4; n++) begin
                r = next_rand();
                @(negedge clk_i);
                cpu_en_i   = 1'b1;
                cpu_we_i   = 4'h0;
                cpu_addr_i = {regions[k], r[23:0]};
                drive_rdata();
                @(negedge clk_i);
                cpu_en_i = 1'b0;
                drive_rdata();
                exp = (k == 0) ? dmem_rdata_i : (k == 1) ? plic_rdata_i : ni_rdata_i;
                #(settle_ns);
                check_val("cpu_rdata_o", 64'(exp), 64'(cpu_rdata_o));
            end
        end
        end_test();
    endtask

    task automatic test_timer();
        logic [31:0] hi_w;
        logic [31:0] lo_w;
        logic [31:0] d;
        logic [31:0] t0;
        begin_test("timer");
        hi_w = next_rand();
        lo_w = next_rand();
        bus_write(rtc_addr(rtc_off_cmp_hi), hi_w);
        bus_write(rtc_addr(rtc_off_cmp_lo), lo_w);
        bus_read(rtc_addr(rtc_off_cmp_hi), d);
        check_val("mtimecmp hi", 64'(hi_w), 64'(d));
        bus_read(rtc_addr(rtc_off_cmp_lo), d);
        check_val("mtimecmp lo", 64'(lo_w), 64'(d));
        bus_read(rtc_addr(rtc_off_mtime_lo), t0);
        bus_read(rtc_addr(rtc_off_mtime_lo), d);
        check_true("mtime low did not advance between two reads", d > t0);
        // Compare at zero raises the interrupt level
        bus_write(rtc_addr(rtc_off_cmp_lo), 32'h0);
        bus_write(rtc_addr(rtc_off_cmp_hi), 32'h0);
        #(settle_ns);
        check_val("mti_o after cmp 0", 64'(1), 64'(mti_o));
        bus_write(rtc_addr(rtc_off_cmp_hi), 32'hFFFF_FFFF);
        bus_write(rtc_addr(rtc_off_cmp_lo), 32'hFFFF_FFFF);
        #(settle_ns);
        check_val("mti_o after cmp max", 64'(0), 64'(mti_o));
        end_test();
    endtask

    task automatic test_split();
        logic [31:0] r;
        logic        mon;
        begin_test("outgoing split");
        for (int n = 0; n < 16; n++) begin
            r = next_rand();
            @(negedge clk_i);
            br_rx_req_i        = 1'b1;
            br_rx_payload_i    = next_rand();
            br_rx_seq_source_i = r[7:0];
            br_rx_producer_i   = r[15:8];
            br_rx_ksvc_i       = r[23:16];
            br_rx_service_i    = r[25:24];
            // Every fourth flit is monitor traffic and the next one never is
            if (n % 4 == 0) begin
                br_rx_service_i = br_svc_mon;
            end else if (n % 4 == 1 && r[25:24] == br_svc_mon) begin
                br_rx_service_i = 2'd3;
            end
            // Acks always disagree so the wrong one would show
            br_mon_ack_i = n[2];
            br_svc_ack_i = !n[2];
            mon = (br_rx_service_i == br_svc_mon);
            #(settle_ns);
            check_val("br_mon_req_o", 64'(mon), 64'(br_mon_req_o));
            check_val("br_svc_req_o", 64'(!mon), 64'(br_svc_req_o));
            check_val("br_mon_payload_o", 64'(br_rx_payload_i), 64'(br_mon_payload_o));
            check_val("br_svc_payload_o", 64'(br_rx_payload_i), 64'(br_svc_payload_o));
            check_val("br_mon_seq_source_o", 64'(r[7:0]), 64'(br_mon_seq_source_o));
            check_val("br_svc_seq_source_o", 64'(r[7:0]), 64'(br_svc_seq_source_o));
            check_val("br_mon_producer_o", 64'(r[15:8]), 64'(br_mon_producer_o));
            check_val("br_svc_producer_o", 64'(r[15:8]), 64'(br_svc_producer_o));
            check_val("br_mon_msvc_o", 64'(r[16 +: br_msvc_w]), 64'(br_mon_msvc_o));
            check_val("br_svc_ksvc_o", 64'(r[23:16]), 64'(br_svc_ksvc_o));
            check_val("br_rx_ack_o", 64'(mon ? br_mon_ack_i : br_svc_ack_i), 64'(br_rx_ack_o));
        end
        @(negedge clk_i);
        br_rx_req_i = 1'b0;
        #(settle_ns);
        check_val("requests when idle", 64'(0), 64'({br_mon_req_o, br_svc_req_o}));
        end_test();
    endtask

    task automatic test_inject();
        logic [31:0] r;
        int unsigned exp_id;
        begin_test("local inject");
        exp_id = 0;
        for (int n = 0; n < 40; n++) begin
            r = next_rand();
            @(negedge clk_i);
            br_ni_req_i        = 1'b1;
            br_ni_payload_i    = next_rand();
            br_ni_seq_target_i = r[7:0];
            br_ni_producer_i   = r[15:8];
            br_ni_ksvc_i       = r[23:16];
            br_ni_service_i    = r[25:24];
            br_tx_ack_i        = 1'b1;
            #(settle_ns);
            check_val("br_tx_req_o", 64'(1), 64'(br_tx_req_o));
            check_val("br_tx_payload_o", 64'(br_ni_payload_i), 64'(br_tx_payload_o));
            check_val("br_tx_seq_target_o", 64'(r[7:0]), 64'(br_tx_seq_target_o));
            check_val("br_tx_seq_source_o", 64'(exp_seq_addr), 64'(br_tx_seq_source_o));
            check_val("br_tx_producer_o", 64'(r[15:8]), 64'(br_tx_producer_o));
            check_val("br_tx_ksvc_o", 64'(r[23:16]), 64'(br_tx_ksvc_o));
            check_val("br_tx_service_o", 64'(r[25:24]), 64'(br_tx_service_o));
            check_val("br_tx_id_o", 64'(exp_id), 64'(br_tx_id_o));
            check_val("br_ni_ack_o", 64'(1), 64'(br_ni_ack_o));
            exp_id = (exp_id + 1) % (1 << br_id_w);
        end
        // Id has to hold while the consumer stalls
        for (int n = 0; n < 4; n++) begin
            @(negedge clk_i);
            br_tx_ack_i = 1'b0;
            #(settle_ns);
            check_val("br_tx_id_o without ack", 64'(exp_id), 64'(br_tx_id_o));
            check_val("br_ni_ack_o without ack", 64'(0), 64'(br_ni_ack_o));
        end
        @(negedge clk_i);
        br_ni_req_i = 1'b0;
        end_test();
    endtask

    initial begin
        rng_state    = 32'h84264612;
        checks_run   = 0;
        tests_run    = 0;
        tests_failed = 0;
        errors_total = 0;
        rst_ni       = 1'b0;
        cpu_en_i     = 1'b0;
        cpu_we_i     = 4'h0;
        cpu_addr_i   = '0;
        cpu_wdata_i  = '0;
        dmem_rdata_i = '0;
        plic_rdata_i = '0;
        ni_rdata_i   = '0;
        br_rx_req_i        = 1'b0;
        br_rx_payload_i    = '0;
        br_rx_seq_source_i = '0;
        br_rx_producer_i   = '0;
        br_rx_ksvc_i       = '0;
        br_rx_service_i    = '0;
        br_mon_ack_i       = 1'b0;
        br_svc_ack_i       = 1'b0;
        br_ni_req_i        = 1'b0;
        br_ni_payload_i    = '0;
        br_ni_seq_target_i = '0;
        br_ni_producer_i   = '0;
        br_ni_ksvc_i       = '0;
        br_ni_service_i    = '0;
        br_tx_ack_i        = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        test_reset();
        test_decode();
        test_read_return();
        test_timer();
        test_split();
        test_inject();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks_run, errors_total);
        if (errors_total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the PE glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_pe_top -Mdir "$BUILD_DIR" -o tb_pe_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_pe_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- src/br_local_port.sv
`timescale 1ns/1ps
`default_nettype none

module br_local_port
    import pe_pkg::*;
#(
    parameter logic [br_addr_w-1:0] seq_addr = '0
)
(
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // From the router local port
    input  logic                    br_rx_req_i,
    input  logic [br_payload_w-1:0] br_rx_payload_i,
    input  logic [br_addr_w-1:0]    br_rx_seq_source_i,
    input  logic [br_addr_w-1:0]    br_rx_producer_i,
    input  logic [7:0]              br_rx_ksvc_i,
    input  logic [br_svc_w-1:0]     br_rx_service_i,
    output logic                    br_rx_ack_o,

    // Monitor channel
    output logic                    br_mon_req_o,
    output logic [br_payload_w-1:0] br_mon_payload_o,
    output logic [br_addr_w-1:0]    br_mon_seq_source_o,
    output logic [br_addr_w-1:0]    br_mon_producer_o,
    output logic [br_msvc_w-1:0]    br_mon_msvc_o,
    input  logic                    br_mon_ack_i,

    // Service channel
    output logic                    br_svc_req_o,
    output logic [br_payload_w-1:0] br_svc_payload_o,
    output logic [br_addr_w-1:0]    br_svc_seq_source_o,
    output logic [br_addr_w-1:0]    br_svc_producer_o,
    output logic [7:0]              br_svc_ksvc_o,
    input  logic                    br_svc_ack_i,

    // From the NI
    input  logic                    br_ni_req_i,
    input  logic [br_payload_w-1:0] br_ni_payload_i,
    input  logic [br_addr_w-1:0]    br_ni_seq_target_i,
    input  logic [br_addr_w-1:0]    br_ni_producer_i,
    input  logic [7:0]              br_ni_ksvc_i,
    input  logic [br_svc_w-1:0]     br_ni_service_i,
    output logic                    br_ni_ack_o,

    // To the router local port
    output logic                    br_tx_req_o,
    output logic [br_payload_w-1:0] br_tx_payload_o,
    output logic [br_addr_w-1:0]    br_tx_seq_target_o,
    output logic [br_addr_w-1:0]    br_tx_seq_source_o,
    output logic [br_addr_w-1:0]    br_tx_producer_o,
    output logic [7:0]              br_tx_ksvc_o,
    output logic [br_svc_w-1:0]     br_tx_service_o,
    output logic [br_id_w-1:0]      br_tx_id_o,
    input  logic                    br_tx_ack_i
);

    //////////////////////////////
    // Outgoing split
    //////////////////////////////

    logic     is_mon;
    br_ksvc_u rx_ksvc;

    assign is_mon  = (br_rx_service_i == br_svc_mon);
    assign rx_ksvc = br_rx_ksvc_i;

    assign br_mon_req_o        = br_rx_req_i && is_mon;
    assign br_mon_payload_o    = br_rx_payload_i;
    assign br_mon_seq_source_o = br_rx_seq_source_i;
    assign br_mon_producer_o   = br_rx_producer_i;
    assign br_mon_msvc_o       = rx_ksvc.mon.msvc;

    assign br_svc_req_o        = br_rx_req_i && !is_mon;
    assign br_svc_payload_o    = br_rx_payload_i;
    assign br_svc_seq_source_o = br_rx_seq_source_i;
    assign br_svc_producer_o   = br_rx_producer_i;
    assign br_svc_ksvc_o       = rx_ksvc.ksvc;

    // only the channel that got the request may ack it
    assign br_rx_ack_o = is_mon ? br_mon_ack_i : br_svc_ack_i;

    //////////////////////////////
    // Incoming stamp
    //////////////////////////////

    logic [br_id_w-1:0] id_q;

    // Next flit id, wraps at the field width
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            id_q <= '0;
        end else if (br_tx_ack_i) begin
            id_q <= id_q + 1'b1;
        end
    end

    assign br_tx_req_o        = br_ni_req_i;
    assign br_tx_payload_o    = br_ni_payload_i;
    assign br_tx_seq_target_o = br_ni_seq_target_i;
    assign br_tx_seq_source_o = seq_addr;
    assign br_tx_producer_o   = br_ni_producer_i;
    assign br_tx_ksvc_o       = br_ni_ksvc_i;
    assign br_tx_service_o    = br_ni_service_i;
    assign br_tx_id_o         = id_q;

    assign br_ni_ack_o = br_tx_ack_i;

endmodule

`default_nettype wire

//--- src/pe_bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module pe_bus_decoder
    import pe_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // CPU data bus
    input  logic                  cpu_en_i,
    input  logic [3:0]            cpu_we_i,
    input  logic [bus_addr_w-1:0] cpu_addr_i,
    input  logic [bus_data_w-1:0] cpu_wdata_i,
    output logic [bus_data_w-1:0] cpu_rdata_o,

    // External targets
    output logic                  dmem_en_o,
    output logic [mem_addr_w-1:0] dmem_addr_o,
    input  logic [bus_data_w-1:0] dmem_rdata_i,
    output logic                  plic_en_o,
    input  logic [bus_data_w-1:0] plic_rdata_i,
    output logic                  ni_en_o,
    input  logic [bus_data_w-1:0] ni_rdata_i,

    // Timer
    periph_bus_if.decoder         rtc_bus
);

    //////////////////////////////
    // Region decode
    //////////////////////////////

    logic [7:0] region;
    logic       rtc_en;

    // Region field sits right above the target offset
    assign region = cpu_addr_i[bus_addr_w-1:mem_addr_w];

    assign dmem_en_o = cpu_en_i && (region == region_dmem);
    assign rtc_en    = cpu_en_i && (region == region_rtc);
    assign plic_en_o = cpu_en_i && (region == region_plic);
    assign ni_en_o   = cpu_en_i && (region == region_ni);

    assign dmem_addr_o = cpu_addr_i[mem_addr_w-1:0];

    // Timer only looks at the word offset
    assign rtc_bus.en    = rtc_en;
    assign rtc_bus.we    = cpu_we_i;
    assign rtc_bus.addr  = cpu_addr_i[3:0];
    assign rtc_bus.wdata = cpu_wdata_i;

    //////////////////////////////
    // Read return
    //////////////////////////////

    logic rtc_sel_q;
    logic plic_sel_q;
    logic ni_sel_q;

    // Remember who was addressed, data comes back next cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rtc_sel_q  <= 1'b0;
            plic_sel_q <= 1'b0;
            ni_sel_q   <= 1'b0;
        end else begin
            rtc_sel_q  <= rtc_en;
            plic_sel_q <= plic_en_o;
            ni_sel_q   <= ni_en_o;
        end
    end

    // Data memory when no peripheral was selected
    always_comb begin
        if (rtc_sel_q) begin
            cpu_rdata_o = rtc_bus.rdata;
        end else if (plic_sel_q) begin
            cpu_rdata_o = plic_rdata_i;
        end else if (ni_sel_q) begin
            cpu_rdata_o = ni_rdata_i;
        end else begin
            cpu_rdata_o = dmem_rdata_i;
        end
    end

endmodule

`default_nettype wire

//--- src/pe_pkg.sv
`default_nettype none

package pe_pkg;

    //////////////////////////////
    // Memory map
    //////////////////////////////

    // Region codes, compared against address bits 31:24
    localparam logic [7:0] region_dmem = 8'h01;
    localparam logic [7:0] region_rtc  = 8'h02;
    localparam logic [7:0] region_plic = 8'h04;
    localparam logic [7:0] region_ni   = 8'h08;

    localparam int unsigned bus_addr_w = 32;
    localparam int unsigned bus_data_w = 32;

    // Offset handed to the external targets
    localparam int unsigned mem_addr_w = 24;

    // Timer word offsets in address bits 3:0
    localparam logic [3:0] rtc_off_mtime_lo = 4'h0;
    localparam logic [3:0] rtc_off_mtime_hi = 4'h4;
    localparam logic [3:0] rtc_off_cmp_lo   = 4'h8;
    localparam logic [3:0] rtc_off_cmp_hi   = 4'hC;

    //////////////////////////////
    // Broadcast flits
    //////////////////////////////

    // Mesh width, for the sequential tile address
    localparam int unsigned n_pe_x = 4;

    localparam int unsigned br_payload_w = 32;
    localparam int unsigned br_addr_w    = 8;
    localparam int unsigned br_id_w      = 5;
    localparam int unsigned br_svc_w     = 2;
    localparam int unsigned br_msvc_w    = 3;

    // Monitor traffic, anything else goes to the service channel
    localparam logic [br_svc_w-1:0] br_svc_mon = 2'd1;

    // Service index field, read as a kernel service code or a monitor index
    typedef union packed {
        logic [7:0] ksvc;
        struct packed {
            logic [7-br_msvc_w:0] unused;
            logic [br_msvc_w-1:0] msvc;
        } mon;
    } br_ksvc_u;

endpackage

`default_nettype wire

//--- src/pe_rtc.sv
`timescale 1ns/1ps
`default_nettype none

module pe_rtc
    import pe_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_ni,
    periph_bus_if.peripheral bus,
    output logic             mti_o
);

    logic [63:0]           mtime_q;
    logic [63:0]           mtime_d;
    logic [63:0]           mtimecmp_q;
    logic [63:0]           mtimecmp_d;
    logic [bus_data_w-1:0] rdata_q;
    logic                  wr;
    logic                  rd;

    assign wr = bus.en && (|bus.we);
    assign rd = bus.en && !(|bus.we);

    //////////////////////////////
    // Counter and compare
    //////////////////////////////

    // A write replaces the addressed word, the counter keeps running otherwise
    always_comb begin
        mtime_d    = mtime_q + 64'd1;
        mtimecmp_d = mtimecmp_q;
        if (wr) begin
            case (bus.addr)
                rtc_off_mtime_lo: mtime_d[31:0]     = bus.wdata;
                rtc_off_mtime_hi: mtime_d[63:32]    = bus.wdata;
                rtc_off_cmp_lo:   mtimecmp_d[31:0]  = bus.wdata;
                rtc_off_cmp_hi:   mtimecmp_d[63:32] = bus.wdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
        end else begin
            mtime_q    <= mtime_d;
            mtimecmp_q <= mtimecmp_d;
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    // Word is ready in the cycle after en
    always_ff @(posedge clk_i) begin
        if (rd) begin
            case (bus.addr)
                rtc_off_mtime_lo: rdata_q <= mtime_q[31:0];
                rtc_off_mtime_hi: rdata_q <= mtime_q[63:32];
                rtc_off_cmp_lo:   rdata_q <= mtimecmp_q[31:0];
                rtc_off_cmp_hi:   rdata_q <= mtimecmp_q[63:32];
                default:          rdata_q <= '0;
            endcase
        end
    end

    assign bus.rdata = rdata_q;

    // Level stays up until mtimecmp is moved past mtime
    assign mti_o = (mtime_q >= mtimecmp_q);

endmodule

`default_nettype wire

//--- src/pe_top.sv
`timescale 1ns/1ps
`default_nettype none

module pe_top
    import pe_pkg::*;
#(
    parameter int unsigned pe_x = 0,
    parameter int unsigned pe_y = 0
)
(
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // CPU data bus
    input  logic                    cpu_en_i,
    input  logic [3:0]              cpu_we_i,
    input  logic [bus_addr_w-1:0]   cpu_addr_i,
    input  logic [bus_data_w-1:0]   cpu_wdata_i,
    output logic [bus_data_w-1:0]   cpu_rdata_o,

    // External targets
    output logic                    dmem_en_o,
    output logic [mem_addr_w-1:0]   dmem_addr_o,
    input  logic [bus_data_w-1:0]   dmem_rdata_i,
    output logic                    plic_en_o,
    input  logic [bus_data_w-1:0]   plic_rdata_i,
    output logic                    ni_en_o,
    input  logic [bus_data_w-1:0]   ni_rdata_i,

    output logic                    mti_o,

    // Router local port, outgoing
    input  logic                    br_rx_req_i,
    input  logic [br_payload_w-1:0] br_rx_payload_i,
    input  logic [br_addr_w-1:0]    br_rx_seq_source_i,
    input  logic [br_addr_w-1:0]    br_rx_producer_i,
    input  logic [7:0]              br_rx_ksvc_i,
    input  logic [br_svc_w-1:0]     br_rx_service_i,
    output logic                    br_rx_ack_o,

    output logic                    br_mon_req_o,
    output logic [br_payload_w-1:0] br_mon_payload_o,
    output logic [br_addr_w-1:0]    br_mon_seq_source_o,
    output logic [br_addr_w-1:0]    br_mon_producer_o,
    output logic [br_msvc_w-1:0]    br_mon_msvc_o,
    input  logic                    br_mon_ack_i,

    output logic                    br_svc_req_o,
    output logic [br_payload_w-1:0] br_svc_payload_o,
    output logic [br_addr_w-1:0]    br_svc_seq_source_o,
    output logic [br_addr_w-1:0]    br_svc_producer_o,
    output logic [7:0]              br_svc_ksvc_o,
    input  logic                    br_svc_ack_i,

    // NI to router local port
    input  logic                    br_ni_req_i,
    input  logic [br_payload_w-1:0] br_ni_payload_i,
    input  logic [br_addr_w-1:0]    br_ni_seq_target_i,
    input  logic [br_addr_w-1:0]    br_ni_producer_i,
    input  logic [7:0]              br_ni_ksvc_i,
    input  logic [br_svc_w-1:0]     br_ni_service_i,
    output logic                    br_ni_ack_o,

    output logic                    br_tx_req_o,
    output logic [br_payload_w-1:0] br_tx_payload_o,
    output logic [br_addr_w-1:0]    br_tx_seq_target_o,
    output logic [br_addr_w-1:0]    br_tx_seq_source_o,
    output logic [br_addr_w-1:0]    br_tx_producer_o,
    output logic [7:0]              br_tx_ksvc_o,
    output logic [br_svc_w-1:0]     br_tx_service_o,
    output logic [br_id_w-1:0]      br_tx_id_o,
    input  logic                    br_tx_ack_i
);

    //////////////////////////////
    // Bus and timer
    //////////////////////////////

    periph_bus_if rtc_bus ();

    pe_bus_decoder u_decoder (
        .clk_i        (clk_i       ),
        .rst_ni       (rst_ni      ),
        .cpu_en_i     (cpu_en_i    ),
        .cpu_we_i     (cpu_we_i    ),
        .cpu_addr_i   (cpu_addr_i  ),
        .cpu_wdata_i  (cpu_wdata_i ),
        .cpu_rdata_o  (cpu_rdata_o ),
        .dmem_en_o    (dmem_en_o   ),
        .dmem_addr_o  (dmem_addr_o ),
        .dmem_rdata_i (dmem_rdata_i),
        .plic_en_o    (plic_en_o   ),
        .plic_rdata_i (plic_rdata_i),
        .ni_en_o      (ni_en_o     ),
        .ni_rdata_i   (ni_rdata_i  ),
        .rtc_bus      (rtc_bus     )
    );

    pe_rtc u_rtc (
        .clk_i  (clk_i  ),
        .rst_ni (rst_ni ),
        .bus    (rtc_bus),
        .mti_o  (mti_o  )
    );

    //////////////////////////////
    // Broadcast local port
    //////////////////////////////

    // Row-major tile index in the mesh
    br_local_port #(
        .seq_addr (br_addr_w'(pe_y * n_pe_x + pe_x))
    )
    u_br_port (.*);

endmodule

`default_nettype wire

//--- src/periph_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Internal peripheral bus, read data returns one cycle after en
interface periph_bus_if
    import pe_pkg::*;
();

    logic                  en;
    logic [3:0]            we;
    logic [3:0]            addr;
    logic [bus_data_w-1:0] wdata;
    logic [bus_data_w-1:0] rdata;

    modport decoder (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport peripheral (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire
